//--- isa_pkg.sv
package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // The two top bits of an opcode give its class
    typedef enum logic [4:0] {
        OP_ADD   = 5'b00000,
        OP_SUB   = 5'b00001,
        OP_SLT   = 5'b00010,
        OP_SLTU  = 5'b00011,
        OP_SEQ   = 5'b00100,
        OP_AND   = 5'b00101,
        OP_OR    = 5'b00110,
        OP_XOR   = 5'b00111,
        OP_NOR   = 5'b01000,
        OP_SLL   = 5'b01001,
        OP_SRL   = 5'b01010,
        OP_SRA   = 5'b01011,
        OP_MUL   = 5'b10000,
        OP_MULH  = 5'b10001,
        OP_MULHU = 5'b10010,
        OP_DIV   = 5'b11000,
        OP_MOD   = 5'b11001,
        OP_DIVU  = 5'b11010,
        OP_MODU  = 5'b11011
    } opcode_t;

    // Class 0x is the ALU
    localparam logic [1:0] CLASS_MUL = 2'b10;
    localparam logic [1:0] CLASS_DIV = 2'b11;

endpackage

//--- ex_pkg.sv
package ex_pkg;

    localparam int DIV_CYCLES = 32;
    localparam int PC_STEP    = 4;
    localparam int SHIFT_W    = 5;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

    // One instruction as handed over by the operand-read stage
    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::opcode_t   opcode;
        isa_pkg::word_t     src1;
        isa_pkg::word_t     src2;
        isa_pkg::reg_addr_t dest;
        logic               is_branch;
        logic               branch_cond;
        logic               is_jirl;
        isa_pkg::word_t     branch_target;
        logic               pred_taken;
        isa_pkg::word_t     pred_target;
    } ex_issue_t;

    typedef struct packed {
        logic           taken;
        isa_pkg::word_t target;
        logic           mispredict;
    } branch_res_t;

    typedef struct packed {
        logic               valid;
        logic               done;
        isa_pkg::word_t     pc;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     result;
        branch_res_t        branch;
    } ex_result_t;

endpackage

//--- alu.sv
module alu (
    input  isa_pkg::opcode_t op,
    input  isa_pkg::word_t   src1,
    input  isa_pkg::word_t   src2,
    output isa_pkg::word_t   result
);

    logic [ex_pkg::SHIFT_W-1:0] shamt;

    // Only the low bits of src2 count as the shift amount
    assign shamt = src2[ex_pkg::SHIFT_W-1:0];

    always_comb begin
        case (op)
            isa_pkg::OP_ADD:
                result = src1 + src2;
            isa_pkg::OP_SUB:
                result = src1 - src2;
            isa_pkg::OP_SLT:
                result = isa_pkg::word_t'($signed(src1) < $signed(src2));
            isa_pkg::OP_SLTU:
                result = isa_pkg::word_t'(src1 < src2);
            isa_pkg::OP_SEQ:
                result = isa_pkg::word_t'(src1 == src2);
            isa_pkg::OP_AND:
                result = src1 & src2;
            isa_pkg::OP_OR:
                result = src1 | src2;
            isa_pkg::OP_XOR:
                result = src1 ^ src2;
            isa_pkg::OP_NOR:
                result = ~(src1 | src2);
            isa_pkg::OP_SLL:
                result = src1 << shamt;
            isa_pkg::OP_SRL:
                result = src1 >> shamt;
            isa_pkg::OP_SRA:
                result = isa_pkg::word_t'($signed(src1) >>> shamt);
            // Multiply and divide results come from their own units
            default:
                result = '0;
        endcase
    end

endmodule

//--- mul_unit.sv
module mul_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  logic             start,
    input  isa_pkg::opcode_t op,
    input  isa_pkg::word_t   src1,
    input  isa_pkg::word_t   src2,
    output logic             done,
    output isa_pkg::word_t   result
);

    logic                              sign_ext;
    logic signed [isa_pkg::XLEN:0]     mul_a;
    logic signed [isa_pkg::XLEN:0]     mul_b;
    logic signed [2*isa_pkg::XLEN+1:0] full_product;
    logic [2*isa_pkg::XLEN-1:0]        product;

    // A 33-bit signed multiply covers both signed and unsigned operands
    assign sign_ext     = (op == isa_pkg::OP_MULH);
    assign mul_a        = {sign_ext & src1[isa_pkg::XLEN-1], src1};
    assign mul_b        = {sign_ext & src2[isa_pkg::XLEN-1], src2};
    assign full_product = mul_a * mul_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (clear) begin
            done <= 1'b0;
        end else if (start && !done) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !done) begin
            product <= full_product[2*isa_pkg::XLEN-1:0];
        end
    end

    assign result = (op == isa_pkg::OP_MUL) ? product[isa_pkg::XLEN-1:0]
                                            : product[2*isa_pkg::XLEN-1:isa_pkg::XLEN];

endmodule

//--- div_unit.sv
module div_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  logic             start,
    input  isa_pkg::opcode_t op,
    input  isa_pkg::word_t   src1,
    input  isa_pkg::word_t   src2,
    output logic             done,
    output isa_pkg::word_t   result
);

    ex_pkg::div_state_t                   state;
    logic [$clog2(ex_pkg::DIV_CYCLES)-1:0] step_cnt;
    logic                                 signed_op;
    isa_pkg::word_t                       dvd_mag;
    isa_pkg::word_t                       dvs_mag;
    isa_pkg::word_t                       quot;
    isa_pkg::word_t                       rem;
    isa_pkg::word_t                       dvs;
    logic                                 q_neg;
    logic                                 r_neg;
    logic [isa_pkg::XLEN+1:0]             trial;

    assign signed_op = (op == isa_pkg::OP_DIV) || (op == isa_pkg::OP_MOD);
    assign dvd_mag   = (signed_op && src1[isa_pkg::XLEN-1]) ? -src1 : src1;
    assign dvs_mag   = (signed_op && src2[isa_pkg::XLEN-1]) ? -src2 : src2;

    // Shift in the next dividend bit and try to subtract the divisor
    assign trial = {1'b0, rem, quot[isa_pkg::XLEN-1]} - {2'b00, dvs};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ex_pkg::DIV_IDLE;
            step_cnt <= '0;
        end else if (clear) begin
            state    <= ex_pkg::DIV_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                ex_pkg::DIV_IDLE: begin
                    if (start) begin
                        state    <= ex_pkg::DIV_BUSY;
                        step_cnt <= '0;
                    end
                end
                ex_pkg::DIV_BUSY: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (int'(step_cnt) == ex_pkg::DIV_CYCLES - 1) begin
                        state <= ex_pkg::DIV_DONE;
                    end
                end
                default: begin
                    state <= ex_pkg::DIV_DONE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ex_pkg::DIV_IDLE && start) begin
            quot  <= dvd_mag;
            rem   <= '0;
            dvs   <= dvs_mag;
            q_neg <= signed_op && (src1[isa_pkg::XLEN-1] ^ src2[isa_pkg::XLEN-1]);
            r_neg <= signed_op && src1[isa_pkg::XLEN-1];
        end else if (state == ex_pkg::DIV_BUSY) begin
            // A borrow means the divisor did not fit, so the old remainder is kept
            if (trial[isa_pkg::XLEN+1]) begin
                rem  <= {rem[isa_pkg::XLEN-2:0], quot[isa_pkg::XLEN-1]};
                quot <= {quot[isa_pkg::XLEN-2:0], 1'b0};
            end else begin
                rem  <= trial[isa_pkg::XLEN-1:0];
                quot <= {quot[isa_pkg::XLEN-2:0], 1'b1};
            end
        end
    end

    assign done = (state == ex_pkg::DIV_DONE);

    always_comb begin
        if (op == isa_pkg::OP_DIV || op == isa_pkg::OP_DIVU) begin
            result = q_neg ? -quot : quot;
        end else begin
            result = r_neg ? -rem : rem;
        end
    end

endmodule

//--- ex_stage.sv
module ex_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               allowout,
    input  logic               in_valid,
    input  ex_pkg::ex_issue_t  issue,
    output logic               ex_ready,
    output logic               ex_stall,
    output ex_pkg::ex_result_t out
);

    ex_pkg::ex_issue_t   ex_q;
    logic                ex_valid;
    logic                accept;
    logic                unit_clear;
    logic [1:0]          op_class;
    logic                is_mul;
    logic                is_div;
    logic                done;
    logic                mul_done;
    logic                div_done;
    isa_pkg::word_t      alu_result;
    isa_pkg::word_t      mul_result;
    isa_pkg::word_t      div_result;
    isa_pkg::word_t      result;
    ex_pkg::branch_res_t branch;

    assign accept     = in_valid && !ex_stall;
    assign unit_clear = flush || accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (!ex_stall) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_q <= issue;
        end
    end

    assign op_class = ex_q.opcode[4:3];
    assign is_mul   = (op_class == isa_pkg::CLASS_MUL);
    assign is_div   = (op_class == isa_pkg::CLASS_DIV);

    alu i_alu (
        .op     (ex_q.opcode),
        .src1   (ex_q.src1),
        .src2   (ex_q.src2),
        .result (alu_result)
    );

    mul_unit i_mul_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (unit_clear),
        .start  (ex_valid && is_mul),
        .op     (ex_q.opcode),
        .src1   (ex_q.src1),
        .src2   (ex_q.src2),
        .done   (mul_done),
        .result (mul_result)
    );

    div_unit i_div_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (unit_clear),
        .start  (ex_valid && is_div),
        .op     (ex_q.opcode),
        .src1   (ex_q.src1),
        .src2   (ex_q.src2),
        .done   (div_done),
        .result (div_result)
    );

    // ALU work finishes in the cycle the instruction sits here
    assign done     = is_mul ? mul_done : (is_div ? div_done : 1'b1);
    assign ex_ready = ex_valid && done;
    assign ex_stall = ex_valid && (!done || !allowout);

    always_comb begin
        if (ex_q.is_jirl) begin
            result = ex_q.pc + isa_pkg::word_t'(ex_pkg::PC_STEP);
        end else if (is_mul) begin
            result = mul_result;
        end else if (is_div) begin
            result = div_result;
        end else begin
            result = alu_result;
        end
    end

    // The compare opcode leaves its outcome in bit 0 of the ALU result
    assign branch.taken  = ex_q.is_branch && (ex_q.is_jirl || ex_q.branch_cond == alu_result[0]);
    assign branch.target = ex_q.is_jirl ? alu_result : ex_q.branch_target;
    assign branch.mispredict = ex_valid && done && allowout &&
                               (branch.taken != ex_q.pred_taken ||
                                (branch.taken && branch.target != ex_q.pred_target));

    always_comb begin
        out.valid  = ex_valid;
        out.done   = ex_ready;
        out.pc     = ex_q.pc;
        out.dest   = ex_q.dest;
        out.result = result;
        out.branch = branch;
    end

endmodule

//--- tb_ex_stage_sva.sv
module ex_stage_sva (
    input logic               clk,
    input logic               rst_n,
    input logic               flush,
    input logic               allowout,
    input logic               in_valid,
    input logic               ex_stall,
    input ex_pkg::ex_result_t out
);
    timeunit 1ns;
    timeprecision 1ps;

    // A finished result waiting on allowout stays put apart from mispredict
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ex_stall && out.done && !flush |=> $stable({out.valid, out.done, out.pc, out.dest,
                                                    out.result, out.branch.taken,
                                                    out.branch.target}))
        else $error("Held result changed while the stage was stalled");

    // A mispredicting instruction leaves and whatever waited behind it is taken in
    a_mispredict: assert property (@(posedge clk) disable iff (!rst_n)
        out.branch.mispredict && !flush |=> $past(out.valid && out.done && allowout) &&
                                            out.valid == $past(in_valid))
        else $error("Mispredict raised outside the cycle the instruction leaves");

    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out.valid)
        else $error("Instruction still valid in the cycle after a flush");

endmodule

bind ex_stage ex_stage_sva i_ex_stage_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .allowout (allowout),
    .in_valid (in_valid),
    .ex_stall (ex_stall),
    .out      (out)
);

//--- tb_ex_stage.sv
module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;

    // About 80 instructions at up to 36 cycles each with a wide margin on top
    localparam int TIMEOUT_CYCLES = 6000;

    logic               clk;
    logic               rst_n;
    logic               flush;
    logic               allowout;
    logic               in_valid;
    ex_pkg::ex_issue_t  issue;
    logic               ex_ready;
    logic               ex_stall;
    ex_pkg::ex_result_t out;
    logic [31:0]        lfsr_state;
    int                 cycle_cnt;
    int                 err_count;
    int                 test_count;

    ex_stage i_ex_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .allowout (allowout),
        .in_valid (in_valid),
        .issue    (issue),
        .ex_ready (ex_ready),
        .ex_stall (ex_stall),
        .out      (out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt == TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, an instruction never completed", cycle_cnt);
        $display("=== FAIL ===");
        $finish;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1 stepped once per bit taken
    function automatic isa_pkg::word_t rand_bits(input int n);
        isa_pkg::word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic isa_pkg::word_t expected_result(input ex_pkg::ex_issue_t ins);
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        logic [63:0]    prod;
        isa_pkg::word_t q;
        isa_pkg::word_t r;
        a = ins.src1;
        b = ins.src2;
        if (ins.is_jirl) begin
            return ins.pc + 32'd4;
        end
        case (ins.opcode)
            isa_pkg::OP_ADD:  return a + b;
            isa_pkg::OP_SUB:  return a - b;
            isa_pkg::OP_SLT:  return {31'b0, $signed(a) < $signed(b)};
            isa_pkg::OP_SLTU: return {31'b0, a < b};
            isa_pkg::OP_SEQ:  return {31'b0, a == b};
            isa_pkg::OP_AND:  return a & b;
            isa_pkg::OP_OR:   return a | b;
            isa_pkg::OP_XOR:  return a ^ b;
            isa_pkg::OP_NOR:  return ~(a | b);
            isa_pkg::OP_SLL:  return a << b[4:0];
            isa_pkg::OP_SRL:  return a >> b[4:0];
            isa_pkg::OP_SRA:  return $signed(a) >>> b[4:0];
            isa_pkg::OP_MUL, isa_pkg::OP_MULH: begin
                prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                return (ins.opcode == isa_pkg::OP_MUL) ? prod[31:0] : prod[63:32];
            end
            isa_pkg::OP_MULHU: begin
                prod = {32'd0, a} * {32'd0, b};
                return prod[63:32];
            end
            isa_pkg::OP_DIV, isa_pkg::OP_MOD: begin
                if (b == '0) begin
                    // The all-ones quotient magnitude takes the sign of the dividend
                    q = a[31] ? 32'd1 : '1;
                    r = a;
                end else begin
                    q = $signed(a) / $signed(b);
                    r = $signed(a) % $signed(b);
                end
                return (ins.opcode == isa_pkg::OP_DIV) ? q : r;
            end
            isa_pkg::OP_DIVU, isa_pkg::OP_MODU: begin
                q = (b == '0) ? '1 : a / b;
                r = (b == '0) ? a : a % b;
                return (ins.opcode == isa_pkg::OP_DIVU) ? q : r;
            end
            default: return '0;
        endcase
    endfunction

    function automatic ex_pkg::branch_res_t expected_branch(input ex_pkg::ex_issue_t ins);
        ex_pkg::branch_res_t br;
        ex_pkg::ex_issue_t   cmp_ins;
        isa_pkg::word_t      cmp;
        cmp_ins = ins;
        cmp_ins.is_jirl = 1'b0;
        cmp = expected_result(cmp_ins);
        br.taken = ins.is_branch && (ins.is_jirl || ins.branch_cond == cmp[0]);
        br.target = ins.is_jirl ? ins.src1 + ins.src2 : ins.branch_target;
        br.mispredict = (br.taken != ins.pred_taken) ||
                        (br.taken && br.target != ins.pred_target);
        return br;
    endfunction

    function automatic ex_pkg::ex_issue_t make_issue(input isa_pkg::opcode_t op,
                                                     isa_pkg::word_t a, isa_pkg::word_t b);
        ex_pkg::ex_issue_t ins;
        ins = '0;
        ins.pc = rand_bits(30) << 2;
        ins.opcode = op;
        ins.src1 = a;
        ins.src2 = b;
        ins.dest = isa_pkg::reg_addr_t'(rand_bits(5));
        return ins;
    endfunction

    task automatic check_word(input string name, isa_pkg::word_t exp, isa_pkg::word_t act);
        if (act !== exp) begin
            err_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_branch(input string name, ex_pkg::branch_res_t exp,
                                ex_pkg::branch_res_t act);
        if (act !== exp) begin
            err_count++;
            $display("[ERROR] %s: expected taken/target/mispredict %b/%h/%b, actual %b/%h/%b",
                     name, exp.taken, exp.target, exp.mispredict,
                     act.taken, act.target, act.mispredict);
        end
    endtask

    task automatic check_flag(input string name, logic exp, logic act);
        if (act !== exp) begin
            err_count++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Returns 10 ns after the edge that took in the driven instruction
    task automatic wait_accept();
        logic taken_in;
        taken_in = 1'b0;
        while (!taken_in) begin
            @(negedge clk);
            taken_in = !ex_stall;
            @(posedge clk);
            #10;
        end
    endtask

    task automatic run_op(input string name, ex_pkg::ex_issue_t ins, output int lat);
        @(posedge clk);
        #10;
        issue = ins;
        in_valid = 1'b1;
        wait_accept();
        in_valid = 1'b0;
        lat = 0;
        @(negedge clk);
        while (!out.done) begin
            check_flag({name, " stall"}, 1'b1, ex_stall);
            lat++;
            @(negedge clk);
        end
        check_word(name, expected_result(ins), out.result);
        check_word({name, " pc"}, ins.pc, out.pc);
        check_word({name, " dest"}, isa_pkg::word_t'(ins.dest), isa_pkg::word_t'(out.dest));
        check_flag({name, " ready"}, 1'b1, ex_ready);
        check_branch(name, expected_branch(ins), out.branch);
    endtask

    task automatic report_test(input string name, int errs_before);
        test_count++;
        $display("test %-13s finished with %0d errors", name, err_count - errs_before);
    endtask

    task automatic test_alu();
        isa_pkg::opcode_t ops [12];
        isa_pkg::word_t   a;
        int               lat;
        int               e0;
        e0 = err_count;
        ops = '{isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_SLT, isa_pkg::OP_SLTU,
                isa_pkg::OP_SEQ, isa_pkg::OP_AND, isa_pkg::OP_OR, isa_pkg::OP_XOR,
                isa_pkg::OP_NOR, isa_pkg::OP_SLL, isa_pkg::OP_SRL, isa_pkg::OP_SRA};
        foreach (ops[i]) begin
            a = rand_bits(32);
            run_op({"alu ", ops[i].name()}, make_issue(ops[i], a, rand_bits(32)), lat);
            check_flag({"alu latency ", ops[i].name()}, 1'b1, lat == 0);
            // Shift amounts of 32 and above
            run_op({"alu ", ops[i].name()}, make_issue(ops[i], a, 32 + rand_bits(5)), lat);
            run_op({"alu ", ops[i].name()}, make_issue(ops[i], a, a), lat);
        end
        report_test("alu", e0);
    endtask

    task automatic test_mul();
        isa_pkg::opcode_t ops [3];
        int               lat;
        int               e0;
        e0 = err_count;
        ops = '{isa_pkg::OP_MUL, isa_pkg::OP_MULH, isa_pkg::OP_MULHU};
        foreach (ops[i]) begin
            repeat (3) begin
                run_op({"mul ", ops[i].name()},
                       make_issue(ops[i], rand_bits(32), rand_bits(32)), lat);
            end
            run_op({"mul ", ops[i].name()},
                   make_issue(ops[i], 32'h8000_0000, 32'h8000_0000), lat);
            run_op({"mul ", ops[i].name()}, make_issue(ops[i], '1, '1), lat);
        end
        report_test("mul", e0);
    endtask

    task automatic test_div();
        isa_pkg::opcode_t ops [4];
        int               lat;
        int               e0;
        e0 = err_count;
        ops = '{isa_pkg::OP_DIV, isa_pkg::OP_MOD, isa_pkg::OP_DIVU, isa_pkg::OP_MODU};
        foreach (ops[i]) begin
            run_op({"div ", ops[i].name()}, make_issue(ops[i], -100, 7), lat);
            run_op({"div ", ops[i].name()}, make_issue(ops[i], 100, -7), lat);
            run_op({"div ", ops[i].name()}, make_issue(ops[i], -100, -7), lat);
            run_op({"div ", ops[i].name()},
                   make_issue(ops[i], rand_bits(31), rand_bits(32) | 1), lat);
        end
        run_op("div DIVU by zero", make_issue(isa_pkg::OP_DIVU, rand_bits(32), '0), lat);
        check_word("div DIVU by zero", 32'hffff_ffff, out.result);
        report_test("div", e0);
    endtask

    task automatic run_branch(input string name, isa_pkg::opcode_t op,
                              isa_pkg::word_t a, isa_pkg::word_t b,
                              logic cond, logic jirl, logic pred, logic bad_target,
                              logic exp_mispredict);
        ex_pkg::ex_issue_t ins;
        int                lat;
        ins = make_issue(op, a, b);
        ins.is_branch = 1'b1;
        ins.branch_cond = cond;
        ins.is_jirl = jirl;
        ins.branch_target = rand_bits(30) << 2;
        ins.pred_taken = pred;
        ins.pred_target = (jirl ? a + b : ins.branch_target) ^ (bad_target ? 32'h10 : 32'h0);
        run_op(name, ins, lat);
        check_flag({name, " mispredict"}, exp_mispredict, out.branch.mispredict);
    endtask

    task automatic test_branch();
        isa_pkg::word_t base;
        int             e0;
        e0 = err_count;
        base = rand_bits(30) << 2;
        run_branch("seq taken hit", isa_pkg::OP_SEQ, 5, 5, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        run_branch("seq untaken miss", isa_pkg::OP_SEQ, 5, 6, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
        run_branch("slt taken miss", isa_pkg::OP_SLT, -5, 3, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        run_branch("slt untaken hit", isa_pkg::OP_SLT, -5, 3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        run_branch("seq bad target", isa_pkg::OP_SEQ, 7, 7, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1);
        run_branch("slt stale target", isa_pkg::OP_SLT, 3, -5, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        run_branch("jirl hit", isa_pkg::OP_ADD, base, 16, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        run_branch("jirl bad target", isa_pkg::OP_ADD, base, 16, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
        report_test("branch", e0);
    endtask

    task automatic test_backpressure();
        ex_pkg::ex_issue_t  ins_a;
        ex_pkg::ex_issue_t  ins_b;
        ex_pkg::ex_result_t held;
        int                 e0;
        e0 = err_count;
        ins_a = make_issue(isa_pkg::OP_XOR, rand_bits(32), rand_bits(32));
        ins_b = make_issue(isa_pkg::OP_SUB, rand_bits(32), rand_bits(32));
        @(posedge clk);
        #10;
        allowout = 1'b0;
        issue = ins_a;
        in_valid = 1'b1;
        wait_accept();
        // The next instruction waits at the input while the first one is held
        issue = ins_b;
        @(negedge clk);
        held = out;
        repeat (3) begin
            @(negedge clk);
            check_flag("backpressure hold", 1'b1, out == held && ex_stall);
        end
        check_word("backpressure held", expected_result(ins_a), out.result);
        @(posedge clk);
        #10;
        allowout = 1'b1;
        wait_accept();
        in_valid = 1'b0;
        @(negedge clk);
        check_word("backpressure queued", expected_result(ins_b), out.result);
        check_flag("backpressure valid", 1'b1, out.valid);
        report_test("backpressure", e0);
    endtask

    task automatic test_flush();
        int lat;
        int e0;
        e0 = err_count;
        @(posedge clk);
        #10;
        issue = make_issue(isa_pkg::OP_DIV, rand_bits(31), rand_bits(32) | 1);
        in_valid = 1'b1;
        wait_accept();
        in_valid = 1'b0;
        repeat (4) @(negedge clk);
        check_flag("flush div busy", 1'b0, out.done);
        @(posedge clk);
        #10;
        flush = 1'b1;
        @(posedge clk);
        #10;
        flush = 1'b0;
        @(negedge clk);
        check_flag("flush valid", 1'b0, out.valid);
        run_op("flush then ADD", make_issue(isa_pkg::OP_ADD, rand_bits(32), rand_bits(32)), lat);
        run_op("flush then DIVU",
               make_issue(isa_pkg::OP_DIVU, rand_bits(32), rand_bits(32) | 1), lat);
        report_test("flush", e0);
    endtask

    initial begin
        rst_n = 1'b0;
        flush = 1'b0;
        allowout = 1'b1;
        in_valid = 1'b0;
        issue = '0;
        lfsr_state = 32'h561f_6ead;
        cycle_cnt = 0;
        err_count = 0;
        test_count = 0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("reset outputs", 1'b0,
                   out.valid || out.done || ex_ready || ex_stall || out.branch.mispredict);
        report_test("reset", 0);
        test_alu();
        test_mul();
        test_div();
        test_branch();
        test_backpressure();
        test_flush();
        $display("%0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- list.f
isa_pkg.sv
ex_pkg.sv
alu.sv
mul_unit.sv
div_unit.sv
ex_stage.sv
tb_ex_stage_sva.sv
tb_ex_stage.sv
